/* hdl/rob_cfg_pkg.sv */
`default_nettype none

package rob_cfg_pkg;

    // reorder buffer depth
    localparam int rob_n_entries = 8;
    localparam int rob_id_width = $clog2(rob_n_entries);

    // architectural register file
    localparam int arf_n_regs = 16;
    localparam int arf_id_width = $clog2(arf_n_regs);

    // datapath widths
    localparam int reg_data_width = 32;
    localparam int addr_width = 32;

endpackage

`default_nettype wire

/* hdl/rob_types_pkg.sv */
`default_nettype none

package rob_types_pkg;

    typedef logic [rob_cfg_pkg::rob_id_width-1:0] rob_id_t;
    typedef logic [rob_cfg_pkg::arf_id_width-1:0] arf_id_t;
    typedef logic [rob_cfg_pkg::reg_data_width-1:0] reg_data_t;
    typedef logic [rob_cfg_pkg::addr_width-1:0] addr_t;

    // what dispatch hands over per instruction
    typedef struct packed {
        logic dst_valid;
        arf_id_t dst_arf_id;
        addr_t pc;
    } rob_dispatch_t;

    // one buffer slot
    // pc_npc holds the pc until a resolved npc replaces it
    typedef struct packed {
        logic dst_valid;
        arf_id_t dst_arf_id;
        addr_t pc_npc;
        logic br_mispred;
        logic reg_ready;
        reg_data_t reg_data;
    } rob_entry_t;

    // alu or load writeback
    typedef struct packed {
        logic valid;
        rob_id_t rob_id;
        reg_data_t reg_data;
    } rob_wb_t;

    // resolved branch from the alu
    typedef struct packed {
        logic valid;
        logic mispred;
        addr_t npc;
    } rob_npc_t;

    typedef struct packed {
        logic valid;
        rob_id_t rob_id;
        logic dst_valid;
        arf_id_t arf_id;
        reg_data_t reg_data;
    } rob_retire_t;

    typedef struct packed {
        logic valid;
        addr_t pc;
    } rob_redirect_t;

endpackage

`default_nettype wire

/* hdl/rob_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_queue #(
    parameter int n_read_ports = 2,
    parameter int n_write_ports = 3
) (
    input wire logic clk,
    input wire logic rst,

    // enqueue at the tail
    input wire logic enq_valid,
    output logic enq_ready,
    input wire rob_types_pkg::rob_entry_t enq_data,
    output rob_types_pkg::rob_id_t enq_id,

    // dequeue from the head
    input wire logic deq_en,
    output rob_types_pkg::rob_entry_t head_data,
    output logic head_occupied,
    output rob_types_pkg::rob_id_t head_id,

    // random access reads
    input wire rob_types_pkg::rob_id_t [n_read_ports-1:0] rd_id,
    output rob_types_pkg::rob_entry_t [n_read_ports-1:0] rd_data,

    // random access writes, higher port index wins
    input wire logic [n_write_ports-1:0] wr_en,
    input wire rob_types_pkg::rob_id_t [n_write_ports-1:0] wr_id,
    input wire rob_types_pkg::rob_entry_t [n_write_ports-1:0] wr_data,

    // whole state for the owner to merge updates against
    output rob_types_pkg::rob_entry_t [rob_cfg_pkg::rob_n_entries-1:0] entries,
    output logic [rob_cfg_pkg::rob_n_entries-1:0] occupied,

    input wire logic flush
);

    // pointers carry one extra wrap bit above the index
    logic [rob_cfg_pkg::rob_id_width:0] head_ptr;
    logic [rob_cfg_pkg::rob_id_width:0] tail_ptr;

    rob_types_pkg::rob_entry_t [rob_cfg_pkg::rob_n_entries-1:0] mem;
    logic [rob_cfg_pkg::rob_n_entries-1:0] occ;

    logic full;
    logic do_enq;
    logic do_deq;

    // same index, opposite wrap bit
    assign full = (head_ptr[rob_cfg_pkg::rob_id_width] != tail_ptr[rob_cfg_pkg::rob_id_width])
        && (head_ptr[rob_cfg_pkg::rob_id_width-1:0] == tail_ptr[rob_cfg_pkg::rob_id_width-1:0]);

    assign enq_ready = !full;
    assign enq_id = tail_ptr[rob_cfg_pkg::rob_id_width-1:0];
    assign head_id = head_ptr[rob_cfg_pkg::rob_id_width-1:0];

    assign head_data = mem[head_id];
    assign head_occupied = occ[head_id];

    assign do_enq = enq_valid && !full;
    // an empty head slot is never dequeued
    assign do_deq = deq_en && occ[head_id];

    assign entries = mem;
    assign occupied = occ;

    always_comb begin
        for (int r = 0; r < n_read_ports; r++) begin
            rd_data[r] = mem[rd_id[r]];
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            occ <= '0;
        end else begin
            if (do_enq) begin
                tail_ptr <= tail_ptr + 1'b1;
                occ[enq_id] <= 1'b1;
            end
            if (do_deq) begin
                head_ptr <= head_ptr + 1'b1;
                occ[head_id] <= 1'b0;
            end
        end
    end

    // payload storage
    // enqueue targets a free slot, so it never meets a port write
    always_ff @(posedge clk) begin
        for (int p = 0; p < n_write_ports; p++) begin
            // stale ids are dropped here
            if (wr_en[p] && occ[wr_id[p]]) begin
                mem[wr_id[p]] <= wr_data[p];
            end
        end
        if (do_enq) begin
            mem[enq_id] <= enq_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/rob.sv */
`timescale 1ns/1ps
`default_nettype none

module rob (
    input wire logic clk,
    input wire logic rst,

    // dispatch, valid/ready
    input wire logic dispatch_valid,
    output logic dispatch_ready,
    output rob_types_pkg::rob_id_t dispatch_rob_id,
    input wire rob_types_pkg::rob_dispatch_t dispatch_data,

    // completion events
    input wire logic iiq_wakeup_valid,
    input wire rob_types_pkg::rob_id_t iiq_wakeup_rob_id,
    input wire rob_types_pkg::rob_wb_t alu_wb,
    input wire rob_types_pkg::rob_npc_t alu_npc,
    input wire rob_types_pkg::rob_wb_t ld_wb,

    // operand reads
    input wire rob_types_pkg::rob_id_t src1_id,
    input wire rob_types_pkg::rob_id_t src2_id,
    output logic src1_ready,
    output logic src2_ready,
    output rob_types_pkg::reg_data_t src1_data,
    output rob_types_pkg::reg_data_t src2_data,

    output rob_types_pkg::rob_retire_t retire,
    output rob_types_pkg::rob_redirect_t redirect,

    input wire logic flush
);

    rob_types_pkg::rob_entry_t dispatch_entry;
    rob_types_pkg::rob_entry_t [rob_cfg_pkg::rob_n_entries-1:0] q_entries;
    logic [rob_cfg_pkg::rob_n_entries-1:0] q_occupied;

    rob_types_pkg::rob_entry_t head_entry;
    logic head_occupied;
    rob_types_pkg::rob_id_t head_id;
    logic head_done;

    rob_types_pkg::rob_id_t [1:0] rd_id;
    rob_types_pkg::rob_entry_t [1:0] rd_data;

    // port 0 wakeup, port 1 alu, port 2 load
    logic [2:0] wr_en;
    rob_types_pkg::rob_id_t [2:0] wr_id;
    rob_types_pkg::rob_entry_t [2:0] wr_data;

    // new entries start not ready and without a mispredict
    always_comb begin
        dispatch_entry = '0;
        dispatch_entry.dst_valid = dispatch_data.dst_valid;
        dispatch_entry.dst_arf_id = dispatch_data.dst_arf_id;
        dispatch_entry.pc_npc = dispatch_data.pc;
    end

    // each port rewrites the slot it hits, starting from what is stored
    always_comb begin
        wr_en = {ld_wb.valid, alu_wb.valid, iiq_wakeup_valid};
        wr_id = {ld_wb.rob_id, alu_wb.rob_id, iiq_wakeup_rob_id};

        wr_data[0] = q_entries[iiq_wakeup_rob_id];
        wr_data[0].reg_ready = 1'b1;

        wr_data[1] = q_entries[alu_wb.rob_id];
        wr_data[1].reg_data = alu_wb.reg_data;
        if (alu_npc.valid) begin
            wr_data[1].pc_npc = alu_npc.npc;
            wr_data[1].br_mispred = alu_npc.mispred;
        end

        // load data is ready as soon as it lands
        wr_data[2] = q_entries[ld_wb.rob_id];
        wr_data[2].reg_data = ld_wb.reg_data;
        wr_data[2].reg_ready = 1'b1;
    end

    assign rd_id = {src2_id, src1_id};

    // a freed slot must not look ready
    assign src1_ready = rd_data[0].reg_ready && q_occupied[src1_id];
    assign src1_data = rd_data[0].reg_data;
    assign src2_ready = rd_data[1].reg_ready && q_occupied[src2_id];
    assign src2_data = rd_data[1].reg_data;

    // head leaves once complete, either as retire or as redirect
    assign head_done = head_occupied && head_entry.reg_ready && !flush;

    always_comb begin
        retire.valid = head_done && !head_entry.br_mispred;
        retire.rob_id = head_id;
        retire.dst_valid = head_entry.dst_valid;
        retire.arf_id = head_entry.dst_arf_id;
        retire.reg_data = head_entry.reg_data;

        redirect.valid = head_done && head_entry.br_mispred;
        redirect.pc = head_entry.pc_npc;
    end

    rob_queue #(
        .n_read_ports(2),
        .n_write_ports(3)
    ) rob_queue_i (
        .clk(clk),
        .rst(rst),
        .enq_valid(dispatch_valid),
        .enq_ready(dispatch_ready),
        .enq_data(dispatch_entry),
        .enq_id(dispatch_rob_id),
        .deq_en(head_done),
        .head_data(head_entry),
        .head_occupied(head_occupied),
        .head_id(head_id),
        .rd_id(rd_id),
        .rd_data(rd_data),
        .wr_en(wr_en),
        .wr_id(wr_id),
        .wr_data(wr_data),
        .entries(q_entries),
        .occupied(q_occupied),
        .flush(flush)
    );

endmodule

`default_nettype wire

/* hdl/arf.sv */
`timescale 1ns/1ps
`default_nettype none

module arf (
    input wire logic clk,
    input wire logic rst,

    // write side, fed straight from the rob head
    input wire rob_types_pkg::rob_retire_t retire,

    // single combinational read port
    input wire rob_types_pkg::arf_id_t rd_id,
    output rob_types_pkg::reg_data_t rd_data
);

    rob_types_pkg::reg_data_t [rob_cfg_pkg::arf_n_regs-1:0] regs;
    logic wr_en;

    // entries with no destination pass through without a write
    assign wr_en = retire.valid && retire.dst_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '0;
        end else if (wr_en) begin
            regs[retire.arf_id] <= retire.reg_data;
        end
    end

    // value written at an edge shows here from the next cycle on
    assign rd_data = regs[rd_id];

endmodule

`default_nettype wire

/* hdl/rob_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_unit (
    input wire logic clk,
    input wire logic rst,

    input wire logic dispatch_valid,
    output logic dispatch_ready,
    output rob_types_pkg::rob_id_t dispatch_rob_id,
    input wire rob_types_pkg::rob_dispatch_t dispatch_data,

    input wire logic iiq_wakeup_valid,
    input wire rob_types_pkg::rob_id_t iiq_wakeup_rob_id,
    input wire rob_types_pkg::rob_wb_t alu_wb,
    input wire rob_types_pkg::rob_npc_t alu_npc,
    input wire rob_types_pkg::rob_wb_t ld_wb,

    input wire rob_types_pkg::rob_id_t src1_id,
    input wire rob_types_pkg::rob_id_t src2_id,
    output logic src1_ready,
    output logic src2_ready,
    output rob_types_pkg::reg_data_t src1_data,
    output rob_types_pkg::reg_data_t src2_data,

    input wire logic flush,

    // retire also drives the arf write port
    output rob_types_pkg::rob_retire_t retire,
    output rob_types_pkg::rob_redirect_t redirect,

    input wire rob_types_pkg::arf_id_t arf_rd_id,
    output rob_types_pkg::reg_data_t arf_rd_data
);

    rob rob_i (
        .clk(clk),
        .rst(rst),
        .dispatch_valid(dispatch_valid),
        .dispatch_ready(dispatch_ready),
        .dispatch_rob_id(dispatch_rob_id),
        .dispatch_data(dispatch_data),
        .iiq_wakeup_valid(iiq_wakeup_valid),
        .iiq_wakeup_rob_id(iiq_wakeup_rob_id),
        .alu_wb(alu_wb),
        .alu_npc(alu_npc),
        .ld_wb(ld_wb),
        .src1_id(src1_id),
        .src2_id(src2_id),
        .src1_ready(src1_ready),
        .src2_ready(src2_ready),
        .src1_data(src1_data),
        .src2_data(src2_data),
        .retire(retire),
        .redirect(redirect),
        .flush(flush)
    );

    arf arf_i (
        .clk(clk),
        .rst(rst),
        .retire(retire),
        .rd_id(arf_rd_id),
        .rd_data(arf_rd_data)
    );

endmodule

`default_nettype wire

/* tb/rob_unit_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_unit_properties (
    input wire logic clk,
    input wire logic rst,
    input wire logic flush,
    input wire logic dispatch_valid,
    input wire logic dispatch_ready,
    input wire rob_types_pkg::rob_dispatch_t dispatch_data,
    input wire logic [rob_cfg_pkg::rob_n_entries-1:0] occupied,
    input wire rob_types_pkg::rob_retire_t retire,
    input wire rob_types_pkg::rob_redirect_t redirect
);

    int fail_count = 0;

    // every slot in flight means the queue is full
    assert property (@(posedge clk) disable iff (rst) &occupied |-> !dispatch_ready)
        else begin
            $error("dispatch_ready high while the queue is full");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst) !(retire.valid && redirect.valid))
        else begin
            $error("retire and redirect valid in the same cycle");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst)
        flush |=> !retire.valid && !redirect.valid)
        else begin
            $error("retire or redirect valid right after a flush");
            fail_count++;
        end

    // held dispatch keeps its payload under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        dispatch_valid && !dispatch_ready |=> dispatch_valid && $stable(dispatch_data))
        else begin
            $error("dispatch dropped or changed while waiting for ready");
            fail_count++;
        end

endmodule

bind rob rob_unit_properties rob_unit_properties_i (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .dispatch_valid(dispatch_valid),
    .dispatch_ready(dispatch_ready),
    .dispatch_data(dispatch_data),
    .occupied(q_occupied),
    .retire(retire),
    .redirect(redirect)
);

`default_nettype wire

/* tb/tb_rob_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rob_unit;

    localparam int n = rob_cfg_pkg::rob_n_entries;
    localparam int idw = rob_cfg_pkg::rob_id_width;
    localparam int max_records = 64;

    logic clk;
    logic rst;
    logic dispatch_valid;
    logic dispatch_ready;
    rob_types_pkg::rob_id_t dispatch_rob_id;
    rob_types_pkg::rob_dispatch_t dispatch_data;
    logic iiq_wakeup_valid;
    rob_types_pkg::rob_id_t iiq_wakeup_rob_id;
    rob_types_pkg::rob_wb_t alu_wb;
    rob_types_pkg::rob_npc_t alu_npc;
    rob_types_pkg::rob_wb_t ld_wb;
    rob_types_pkg::rob_id_t src1_id;
    rob_types_pkg::rob_id_t src2_id;
    logic src1_ready;
    logic src2_ready;
    rob_types_pkg::reg_data_t src1_data;
    rob_types_pkg::reg_data_t src2_data;
    logic flush;
    rob_types_pkg::rob_retire_t retire;
    rob_types_pkg::rob_redirect_t redirect;
    rob_types_pkg::arf_id_t arf_rd_id;
    rob_types_pkg::reg_data_t arf_rd_data;

    // four hex words per record, op then three arguments
    logic [31:0] stim [4*max_records];

    // reference queue
    rob_types_pkg::rob_entry_t model_q [n];
    logic model_occ [n];
    int model_head;
    int model_tail;
    int model_count;
    logic pending;
    logic arf_check;
    logic src_check;
    logic [31:0] arf_expect;
    int errors;
    int test_base;
    int cycles;
    int cycle_limit;
    logic [31:0] lfsr;

    rob_unit rob_unit_i (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h80200003;
        return s >> 1;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
            input logic [31:0] expected);
        $display("FAILED t=%0t %s got %h expected %h", $time, name, got, expected);
        errors++;
    endtask

    task automatic check_src(input string name, input rob_types_pkg::rob_id_t id,
            input logic rdy, input rob_types_pkg::reg_data_t data);
        logic exp_rdy;
        exp_rdy = model_occ[id] && model_q[id].reg_ready;
        if (rdy !== exp_rdy)
            report_mismatch({name, "_ready"}, rdy, exp_rdy);
        if (model_occ[id] && data !== model_q[id].reg_data)
            report_mismatch({name, "_data"}, data, model_q[id].reg_data);
    endtask

    // check mid-cycle, then carry the model across the next rising edge
    task automatic step_cycle();
        rob_types_pkg::rob_entry_t old_q [n];
        rob_types_pkg::rob_entry_t h;
        logic done;
        logic room;
        #1;
        h = model_q[model_head];
        done = model_occ[model_head] && h.reg_ready && !flush;
        room = model_count < n;
        if (dispatch_ready !== room)
            report_mismatch("dispatch_ready", dispatch_ready, room);
        if (retire.valid !== (done && !h.br_mispred))
            report_mismatch("retire.valid", retire.valid, done && !h.br_mispred);
        if (redirect.valid !== (done && h.br_mispred))
            report_mismatch("redirect.valid", redirect.valid, done && h.br_mispred);
        if (done && !h.br_mispred) begin
            if (retire.rob_id !== model_head)
                report_mismatch("retire.rob_id", retire.rob_id, model_head);
            if (retire.dst_valid !== h.dst_valid)
                report_mismatch("retire.dst_valid", retire.dst_valid, h.dst_valid);
            if (retire.arf_id !== h.dst_arf_id)
                report_mismatch("retire.arf_id", retire.arf_id, h.dst_arf_id);
            if (retire.reg_data !== h.reg_data)
                report_mismatch("retire.reg_data", retire.reg_data, h.reg_data);
        end
        if (done && h.br_mispred && redirect.pc !== h.pc_npc)
            report_mismatch("redirect.pc", redirect.pc, h.pc_npc);
        if (arf_check && arf_rd_data !== arf_expect)
            report_mismatch("arf_rd_data", arf_rd_data, arf_expect);
        if (src_check) begin
            check_src("src1", src1_id, src1_ready, src1_data);
            check_src("src2", src2_id, src2_ready, src2_data);
        end
        old_q = model_q;
        if (flush) begin
            model_head = 0;
            model_tail = 0;
            model_count = 0;
            foreach (model_occ[i])
                model_occ[i] = 1'b0;
        end else begin
            // on a shared id the later port replaces the whole entry
            if (iiq_wakeup_valid && model_occ[iiq_wakeup_rob_id])
                model_q[iiq_wakeup_rob_id].reg_ready = 1'b1;
            if (alu_wb.valid && model_occ[alu_wb.rob_id]) begin
                model_q[alu_wb.rob_id] = old_q[alu_wb.rob_id];
                model_q[alu_wb.rob_id].reg_data = alu_wb.reg_data;
                if (alu_npc.valid) begin
                    model_q[alu_wb.rob_id].pc_npc = alu_npc.npc;
                    model_q[alu_wb.rob_id].br_mispred = alu_npc.mispred;
                end
            end
            if (ld_wb.valid && model_occ[ld_wb.rob_id]) begin
                model_q[ld_wb.rob_id] = old_q[ld_wb.rob_id];
                model_q[ld_wb.rob_id].reg_data = ld_wb.reg_data;
                model_q[ld_wb.rob_id].reg_ready = 1'b1;
            end
            if (done) begin
                model_occ[model_head] = 1'b0;
                model_head = (model_head + 1) % n;
                model_count--;
            end
            if (dispatch_valid && room) begin
                if (dispatch_rob_id !== model_tail)
                    report_mismatch("dispatch_rob_id", dispatch_rob_id, model_tail);
                model_q[model_tail] = '0;
                model_q[model_tail].dst_valid = dispatch_data.dst_valid;
                model_q[model_tail].dst_arf_id = dispatch_data.dst_arf_id;
                model_q[model_tail].pc_npc = dispatch_data.pc;
                model_occ[model_tail] = 1'b1;
                model_tail = (model_tail + 1) % n;
                model_count++;
                pending = 1'b0;
            end
        end
        @(negedge clk);
        iiq_wakeup_valid = 1'b0;
        alu_wb.valid = 1'b0;
        alu_npc.valid = 1'b0;
        ld_wb.valid = 1'b0;
        flush = 1'b0;
        arf_check = 1'b0;
        src_check = 1'b0;
        if (!pending)
            dispatch_valid = 1'b0;
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("Done: errors found");
            $finish;
        end
    endtask

    initial begin
        int nrec;
        int gap;
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        clk = 1'b0;
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_data = '0;
        iiq_wakeup_valid = 1'b0;
        iiq_wakeup_rob_id = '0;
        alu_wb = '0;
        alu_npc = '0;
        ld_wb = '0;
        src1_id = '0;
        src2_id = '0;
        flush = 1'b0;
        arf_rd_id = '0;
        pending = 1'b0;
        arf_check = 1'b0;
        src_check = 1'b0;
        arf_expect = '0;
        errors = 0;
        test_base = 0;
        cycles = 0;
        model_head = 0;
        model_tail = 0;
        model_count = 0;
        foreach (model_occ[i])
            model_occ[i] = 1'b0;
        lfsr = 32'h097ea20d;
        $readmemh("tb/rob_unit_stim.txt", stim);
        nrec = 0;
        while (nrec < max_records && stim[4*nrec] !== 32'hf && !$isunknown(stim[4*nrec]))
            nrec++;
        cycle_limit = nrec * 8 + 200;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < nrec; r++) begin
            op = stim[4*r];
            a = stim[4*r+1];
            b = stim[4*r+2];
            c = stim[4*r+3];
            case (op)
                0: repeat (a) step_cycle();
                1: begin
                    // one dispatch in flight at a time
                    while (pending)
                        step_cycle();
                    dispatch_valid = 1'b1;
                    dispatch_data.dst_arf_id = a[rob_cfg_pkg::arf_id_width-1:0];
                    dispatch_data.dst_valid = b[0];
                    dispatch_data.pc = c;
                    pending = 1'b1;
                    step_cycle();
                end
                2: begin
                    iiq_wakeup_valid = 1'b1;
                    iiq_wakeup_rob_id = a[idw-1:0];
                    step_cycle();
                end
                3, 4: begin
                    alu_wb = {1'b1, a[idw-1:0], b};
                    alu_npc = {op == 4, a[4], c};
                    step_cycle();
                end
                5: begin
                    ld_wb = {1'b1, a[idw-1:0], b};
                    step_cycle();
                end
                6: begin
                    while (pending)
                        step_cycle();
                    // wake the head as well so a surviving entry would retire
                    iiq_wakeup_valid = 1'b1;
                    iiq_wakeup_rob_id = rob_types_pkg::rob_id_t'(model_head);
                    flush = 1'b1;
                    step_cycle();
                end
                7: begin
                    arf_rd_id = a[rob_cfg_pkg::arf_id_width-1:0];
                    arf_expect = b;
                    arf_check = 1'b1;
                    step_cycle();
                end
                8: begin
                    src1_id = a[idw-1:0];
                    src2_id = b[idw-1:0];
                    src_check = 1'b1;
                    step_cycle();
                end
                9: begin
                    // all three ports on one id
                    iiq_wakeup_valid = 1'b1;
                    iiq_wakeup_rob_id = a[idw-1:0];
                    alu_wb = {1'b1, a[idw-1:0], b};
                    ld_wb = {1'b1, a[idw-1:0], c};
                    step_cycle();
                end
                32'he: begin
                    $display("test %0d finished with %0d errors", a, errors - test_base);
                    test_base = errors;
                end
                default: begin
                    $display("unknown stimulus op %h in record %0d", op, r);
                    errors++;
                end
            endcase
            gap = 0;
            repeat (2) begin
                gap = (gap << 1) | lfsr[0];
                lfsr = lfsr_next(lfsr);
            end
            repeat (gap) step_cycle();
        end
        while (pending)
            step_cycle();
        errors += rob_unit_i.rob_i.rob_unit_properties_i.fail_count;
        $display("%0d records, %0d cycles, %0d errors", nrec, cycles, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* rob_unit.f */
hdl/rob_cfg_pkg.sv
hdl/rob_types_pkg.sv
hdl/rob_queue.sv
hdl/rob.sv
hdl/arf.sv
hdl/rob_unit.sv
tb/rob_unit_properties.sv
tb/tb_rob_unit.sv

/* Bender.yml */
package:
  name: rob_unit

sources:
  - hdl/rob_cfg_pkg.sv
  - hdl/rob_types_pkg.sv
  - hdl/rob_queue.sv
  - hdl/rob.sv
  - hdl/arf.sv
  - hdl/rob_unit.sv
  - target: test
    files:
      - tb/rob_unit_properties.sv
      - tb/tb_rob_unit.sv

/* tb/rob_unit_stim.txt */
// op a b c in hex, one record per line; 0 idle a cycles, 1 dispatch arf a dst_valid b pc c
// 2 wakeup, 3 alu wb, 4 alu wb+npc (a[4] mispred), 5 load, 6 flush, 7 arf a expect b,
// 8 src ids a b, 9 wakeup+alu b+load c on id a, e test done, f end
1 1 1 00001000
1 2 1 00001004
1 3 1 00001008
1 4 1 0000100c
1 5 1 00001010
1 6 1 00001014
1 7 1 00001018
1 8 1 0000101c
1 1 0 00001020
0 3 0 0
5 0 0000aaaa 0
e 1 0 0
2 3 0 0
8 3 2 0
3 2 00000022 0
2 2 0 0
9 5 00000055 00005555
8 5 2 0
5 4 00000044 0
e 2 0 0
5 1 00000011 0
0 8 0 0
7 2 00000011 0
7 3 00000022 0
7 6 00005555 0
5 7 00000077 0
5 6 00000066 0
2 0 0 0
0 6 0 0
7 8 00000077 0
7 1 0000aaaa 0
e 3 0 0
1 9 1 00002000
1 a 1 00002004
4 11 00000099 00003000
2 1 0 0
5 2 000000bb 0
0 6 0 0
7 9 0 0
7 a 000000bb 0
e 4 0 0
1 b 1 00004000
1 c 1 00004004
6 0 0 0
1 c 1 00005000
5 0 000000ee 0
0 6 0 0
7 c 000000ee 0
7 2 00000011 0
e 5 0 0
f 0 0 0
